// File: rtl/pcm_pkg.sv
// shared constants for the pcm player: widths, register map, sample and gain options
package pcm_pkg;

    // sample ROM address width, per channel
    localparam int ROM_AW = 17;
    // signed sample coming out of a channel
    localparam int SMP_W = 7;
    // signed mixed output
    localparam int OUT_W = 8;
    // prescaler counter
    localparam int PRE_W = 12;
    // per-channel volume
    localparam int GAIN_W = 4;

    // ROM bytes are offset binary in the low 7 bits
    localparam int SMP_OFFSET = 64;

    // number of host-visible registers
    localparam int REG_COUNT = 14;

    // channel A block
    localparam logic [3:0] REG_A_PRE_LO = 4'd0;
    localparam logic [3:0] REG_A_PRE_HI = 4'd1;
    localparam logic [3:0] REG_A_START0 = 4'd2;
    localparam logic [3:0] REG_A_START1 = 4'd3;
    localparam logic [3:0] REG_A_START2 = 4'd4;
    localparam logic [3:0] REG_A_PLAY = 4'd5;

    // channel B block, same layout six up
    localparam logic [3:0] REG_B_PRE_LO = 4'd6;
    localparam logic [3:0] REG_B_PRE_HI = 4'd7;
    localparam logic [3:0] REG_B_START0 = 4'd8;
    localparam logic [3:0] REG_B_START1 = 4'd9;
    localparam logic [3:0] REG_B_START2 = 4'd10;
    localparam logic [3:0] REG_B_PLAY = 4'd11;

    // shared registers
    localparam logic [3:0] REG_GAIN = 4'd12;
    localparam logic [3:0] REG_LOOP = 4'd13;

    // channel A volume sits in the upper nibble of the gain register
    localparam bit GAIN_A_HIGH = 1'b1;
    // original silicon swapped A0 on the host bus
    localparam bit INVERT_A0 = 1'b0;
    // product scaling after the gain multiply
    localparam int GAIN_SHIFT = 4;

endpackage

// File: rtl/pcm_rom_if.sv
// per-channel sample ROM bundle with channel and memory modports
`timescale 1ns/1ps

interface pcm_rom_if;

    // byte address into the sample ROM
    logic [pcm_pkg::ROM_AW-1:0] addr;
    // request, held while the channel is playing
    logic                       cs;
    // ROM byte for addr
    logic [7:0]                 dout;
    // dout valid for the current addr
    logic                       ok;

    modport channel (
        output addr, cs,
        input  dout, ok
    );

    modport memory (
        input  addr, cs,
        output dout, ok
    );

endinterface

// File: rtl/pcm_regs.sv
// host register file, play trigger pulses, channel field decode and E/Q enables
`timescale 1ns/1ps

module pcm_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  logic                       dacs,
    input  logic [3:0]                 addr,
    input  logic [7:0]                 din,
    // channel A controls
    output logic [pcm_pkg::ROM_AW-1:0] a_start,
    output logic [pcm_pkg::PRE_W-1:0]  a_pre0,
    output logic [1:0]                 a_pre_sel,
    output logic                       a_loop,
    output logic                       a_play,
    // channel B controls
    output logic [pcm_pkg::ROM_AW-1:0] b_start,
    output logic [pcm_pkg::PRE_W-1:0]  b_pre0,
    output logic [1:0]                 b_pre_sel,
    output logic                       b_loop,
    output logic                       b_play,
    // shared
    output logic [pcm_pkg::GAIN_W-1:0] gain_a,
    output logic [pcm_pkg::GAIN_W-1:0] gain_b,
    output logic                       cen_q,
    output logic                       cen_e
);

    logic [7:0] mmr [pcm_pkg::REG_COUNT];
    logic [3:0] addrj;
    logic [1:0] eq_phase;

    // optional A0 swap of the original part
    assign addrj = pcm_pkg::INVERT_A0 ? (addr ^ 4'b0001) : addr;

    // every dacs cycle is a write, no separate we
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < pcm_pkg::REG_COUNT; i++) begin
                mmr[i] <= 8'd0;
            end
            a_play <= 1'b0;
            b_play <= 1'b0;
        end else begin
            if (dacs && addrj < pcm_pkg::REG_COUNT) begin
                mmr[addrj] <= din;
            end
            // trigger pulse follows the write by one cycle
            a_play <= dacs && addrj == pcm_pkg::REG_A_PLAY;
            b_play <= dacs && addrj == pcm_pkg::REG_B_PLAY;
        end
    end

    // prescaler reload value is 12 bits over lo and hi
    assign a_pre0    = {mmr[pcm_pkg::REG_A_PRE_HI][3:0], mmr[pcm_pkg::REG_A_PRE_LO]};
    assign a_pre_sel = mmr[pcm_pkg::REG_A_PRE_HI][5:4];
    // only bit 0 of the top start byte is kept
    assign a_start   = {mmr[pcm_pkg::REG_A_START2][0], mmr[pcm_pkg::REG_A_START1],
                        mmr[pcm_pkg::REG_A_START0]};
    assign a_loop    = mmr[pcm_pkg::REG_LOOP][0];

    assign b_pre0    = {mmr[pcm_pkg::REG_B_PRE_HI][3:0], mmr[pcm_pkg::REG_B_PRE_LO]};
    assign b_pre_sel = mmr[pcm_pkg::REG_B_PRE_HI][5:4];
    assign b_start   = {mmr[pcm_pkg::REG_B_START2][0], mmr[pcm_pkg::REG_B_START1],
                        mmr[pcm_pkg::REG_B_START0]};
    assign b_loop    = mmr[pcm_pkg::REG_LOOP][1];

    // nibble select per board wiring
    assign gain_a = pcm_pkg::GAIN_A_HIGH ? mmr[pcm_pkg::REG_GAIN][7:4]
                                         : mmr[pcm_pkg::REG_GAIN][3:0];
    assign gain_b = pcm_pkg::GAIN_A_HIGH ? mmr[pcm_pkg::REG_GAIN][3:0]
                                         : mmr[pcm_pkg::REG_GAIN][7:4];

    // 6809 style E/Q, one pulse each per four cen, half a cycle apart
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eq_phase <= 2'd0;
            cen_q    <= 1'b0;
            cen_e    <= 1'b0;
        end else begin
            if (cen) begin
                eq_phase <= eq_phase + 2'd1;
            end
            cen_q <= cen && eq_phase == 2'd1;
            cen_e <= cen && eq_phase == 2'd3;
        end
    end

    // the two host phases must never overlap
    a_eq_exclusive: assert property (@(posedge clk) disable iff (rst) !(cen_q && cen_e));

    // back-to-back dacs on a play register would stretch the trigger
    a_play_pulse: assert property (@(posedge clk) disable iff (rst) a_play |=> !a_play);
    b_play_pulse: assert property (@(posedge clk) disable iff (rst) b_play |=> !b_play);

endmodule

// File: rtl/pcm_channel.sv
// one playback channel: prescaler, ROM address walker, end marker and loop, sample conversion
`timescale 1ns/1ps

module pcm_channel (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cen_q,
    input  logic [pcm_pkg::ROM_AW-1:0]       start,
    input  logic [pcm_pkg::PRE_W-1:0]        pre0,
    input  logic [1:0]                       pre_sel,
    input  logic                             loop,
    input  logic                             play,
    pcm_rom_if.channel                       rom,
    output logic signed [pcm_pkg::SMP_W-1:0] smp
);

    logic [pcm_pkg::PRE_W-1:0]  cnt;
    logic                       over;
    logic                       period_end;
    logic                       busy;
    logic                       playl;
    logic                       play_rise;
    logic                       step_pending;
    logic                       ok_mask;
    logic                       step;
    logic [pcm_pkg::ROM_AW-1:0] rom_addr;
    logic [pcm_pkg::SMP_W-1:0]  smp_raw;

    // terminal count depends on which counter field is in use
    assign over = pre_sel[0] ? (&cnt[7:0]) :
                  pre_sel[1] ? (&cnt[11:8]) : (&cnt);
    assign period_end = cen_q && over;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cen_q) begin
            // reload tick counts as part of the period
            if (over) begin
                cnt <= pre0;
            end else begin
                cnt <= cnt + 1'd1;
            end
        end
    end

    assign play_rise = play && !playl;
    // ok from before an address change is stale
    assign step      = busy && step_pending && rom.ok && !ok_mask;
    // offset binary to two's complement, wraps in 7 bits
    assign smp_raw   = rom.dout[pcm_pkg::SMP_W-1:0] - pcm_pkg::SMP_W'(pcm_pkg::SMP_OFFSET);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            playl        <= 1'b0;
            busy         <= 1'b0;
            step_pending <= 1'b0;
            ok_mask      <= 1'b0;
            rom_addr     <= '0;
            smp          <= '0;
        end else begin
            playl   <= play;
            ok_mask <= play_rise || step;

            // one pending step at most, extra period ends are absorbed
            if (play_rise) begin
                step_pending <= 1'b0;
            end else if (period_end && busy) begin
                step_pending <= 1'b1;
            end else if (step || !busy) begin
                step_pending <= 1'b0;
            end

            if (play_rise) begin
                // retrigger restarts even mid-sample
                busy     <= 1'b1;
                rom_addr <= start;
            end else if (step) begin
                smp <= smp_raw;
                if (!rom.dout[7]) begin
                    rom_addr <= rom_addr + 1'd1;
                end else if (loop) begin
                    rom_addr <= start;
                end else begin
                    busy <= 1'b0;
                end
            end else if (!busy) begin
                // silence once stopped
                smp <= '0;
            end
        end
    end

    assign rom.addr = rom_addr;
    assign rom.cs   = busy;

    // the memory sees a steady address for as long as a step waits on ok
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (rom.cs && step_pending && !step && !play_rise) |=> $stable(rom.addr));

endmodule

// File: rtl/pcm_mixer.sv
// gain scaling and registered sum of the two channel samples
`timescale 1ns/1ps

module pcm_mixer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic signed [pcm_pkg::SMP_W-1:0] smp_a,
    input  logic signed [pcm_pkg::SMP_W-1:0] smp_b,
    input  logic [pcm_pkg::GAIN_W-1:0]       gain_a,
    input  logic [pcm_pkg::GAIN_W-1:0]       gain_b,
    output logic signed [pcm_pkg::OUT_W-1:0] snd
);

    // sample times unsigned gain, one guard bit for the sign
    logic signed [pcm_pkg::SMP_W+pcm_pkg::GAIN_W:0]   prod_a;
    logic signed [pcm_pkg::SMP_W+pcm_pkg::GAIN_W:0]   prod_b;
    // one more bit for the add
    logic signed [pcm_pkg::SMP_W+pcm_pkg::GAIN_W+1:0] sum;
    logic signed [pcm_pkg::SMP_W+pcm_pkg::GAIN_W+1:0] scaled;

    // gains are zero extended so they stay positive
    assign prod_a = smp_a * $signed({1'b0, gain_a});
    assign prod_b = smp_b * $signed({1'b0, gain_b});
    assign sum    = prod_a + prod_b;
    // arithmetic shift keeps the sign
    assign scaled = sum >>> pcm_pkg::GAIN_SHIFT;

    // worst case is 2 x 64 x 15 >> 4, no clip needed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd <= '0;
        end else begin
            snd <= scaled[pcm_pkg::OUT_W-1:0];
        end
    end

    // truncation to OUT_W loses nothing for any sample and gain pair
    a_mix_range: assert property (@(posedge clk) disable iff (rst)
        (scaled >= -(2 ** (pcm_pkg::OUT_W - 1))) && (scaled < 2 ** (pcm_pkg::OUT_W - 1)));

endmodule

// File: rtl/pcm_sound_top.sv
// pcm player top: register file, two channels with their ROM bundles, and the mixer
`timescale 1ns/1ps

module pcm_sound_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cen,
    // host strobe bus
    input  logic                             dacs,
    input  logic [3:0]                       addr,
    input  logic [7:0]                       din,
    // 6809 style enables
    output logic                             cen_q,
    output logic                             cen_e,
    // channel A sample ROM
    output logic [pcm_pkg::ROM_AW-1:0]       roma_addr,
    output logic                             roma_cs,
    input  logic [7:0]                       roma_dout,
    input  logic                             roma_ok,
    // channel B sample ROM
    output logic [pcm_pkg::ROM_AW-1:0]       romb_addr,
    output logic                             romb_cs,
    input  logic [7:0]                       romb_dout,
    input  logic                             romb_ok,
    // raw channel samples and the mix
    output logic signed [pcm_pkg::SMP_W-1:0] snda,
    output logic signed [pcm_pkg::SMP_W-1:0] sndb,
    output logic signed [pcm_pkg::OUT_W-1:0] snd
);

    logic [pcm_pkg::ROM_AW-1:0] a_start;
    logic [pcm_pkg::PRE_W-1:0]  a_pre0;
    logic [1:0]                 a_pre_sel;
    logic                       a_loop;
    logic                       a_play;
    logic [pcm_pkg::ROM_AW-1:0] b_start;
    logic [pcm_pkg::PRE_W-1:0]  b_pre0;
    logic [1:0]                 b_pre_sel;
    logic                       b_loop;
    logic                       b_play;
    logic [pcm_pkg::GAIN_W-1:0] gain_a;
    logic [pcm_pkg::GAIN_W-1:0] gain_b;

    pcm_rom_if u_roma ();
    pcm_rom_if u_romb ();

    // memory side of each bundle goes straight to pins
    assign roma_addr    = u_roma.addr;
    assign roma_cs      = u_roma.cs;
    assign u_roma.dout  = roma_dout;
    assign u_roma.ok    = roma_ok;
    assign romb_addr    = u_romb.addr;
    assign romb_cs      = u_romb.cs;
    assign u_romb.dout  = romb_dout;
    assign u_romb.ok    = romb_ok;

    pcm_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .dacs      (dacs),
        .addr      (addr),
        .din       (din),
        .a_start   (a_start),
        .a_pre0    (a_pre0),
        .a_pre_sel (a_pre_sel),
        .a_loop    (a_loop),
        .a_play    (a_play),
        .b_start   (b_start),
        .b_pre0    (b_pre0),
        .b_pre_sel (b_pre_sel),
        .b_loop    (b_loop),
        .b_play    (b_play),
        .gain_a    (gain_a),
        .gain_b    (gain_b),
        .cen_q     (cen_q),
        .cen_e     (cen_e)
    );

    // both channels run from the Q enable
    pcm_channel u_cha (
        .clk     (clk),
        .rst     (rst),
        .cen_q   (cen_q),
        .start   (a_start),
        .pre0    (a_pre0),
        .pre_sel (a_pre_sel),
        .loop    (a_loop),
        .play    (a_play),
        .rom     (u_roma.channel),
        .smp     (snda)
    );

    pcm_channel u_chb (
        .clk     (clk),
        .rst     (rst),
        .cen_q   (cen_q),
        .start   (b_start),
        .pre0    (b_pre0),
        .pre_sel (b_pre_sel),
        .loop    (b_loop),
        .play    (b_play),
        .rom     (u_romb.channel),
        .smp     (sndb)
    );

    pcm_mixer u_mixer (
        .clk    (clk),
        .rst    (rst),
        .smp_a  (snda),
        .smp_b  (sndb),
        .gain_a (gain_a),
        .gain_b (gain_b),
        .snd    (snd)
    );

endmodule

// File: sim/tb_pcm_sound.sv
// testbench for the pcm player: ROM models, register shadow, reference checks and timeout
`timescale 1ns/1ps

module tb_pcm_sound;

    // step budget over all plays, worst step and worst first period in cycles
    localparam int STEP_BUDGET = 130;
    localparam int STEP_CYC    = 144;
    localparam int PLAYS       = 8;
    // first period can need a full 12-bit count, 8 cycles per cen_q tick
    localparam int FIRST_CYC   = 4096 * 8;
    localparam int TIMEOUT     = 2 * (STEP_BUDGET * STEP_CYC + PLAYS * FIRST_CYC);

    logic                    clk;
    logic                    rst;
    logic                    cen;
    logic                    dacs;
    logic [3:0]              addr;
    logic [7:0]              din;
    logic                    cen_q;
    logic                    cen_e;
    logic [16:0]             roma_addr;
    logic                    roma_cs;
    logic [7:0]              roma_dout;
    logic                    roma_ok;
    logic [16:0]             romb_addr;
    logic                    romb_cs;
    logic [7:0]              romb_dout;
    logic                    romb_ok;
    logic signed [6:0]       snda;
    logic signed [6:0]       sndb;
    logic signed [7:0]       snd;

    integer     seed;
    integer     dly_seed;
    int         errors;
    int         checks;
    string      test_name;
    // ROM images, register shadow and its copy from the previous falling edge
    logic [7:0] rom [2][512];
    logic [7:0] regs [14];
    logic [7:0] regs_p [14];
    int         cyc;
    int         trig [2];
    int         done_cnt [2];
    int         loops [2];
    int         steps_seen [2];
    int         ticks [2];
    int         max_delay [2];
    bit         check_period;
    bit         mon_valid;
    logic       cs_p [2];
    logic [16:0] addr_p [2];
    logic [6:0] smp_p [2];
    int         since_q;
    int         eq_pulses;
    bit         q_seen;
    // ROM model state
    logic       ok_v [2];
    logic [7:0] dout_v [2];
    logic [16:0] cur [2];
    int         wt [2];
    bit         fresh [2];

    pcm_sound_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .dacs      (dacs),
        .addr      (addr),
        .din       (din),
        .cen_q     (cen_q),
        .cen_e     (cen_e),
        .roma_addr (roma_addr),
        .roma_cs   (roma_cs),
        .roma_dout (roma_dout),
        .roma_ok   (roma_ok),
        .romb_addr (romb_addr),
        .romb_cs   (romb_cs),
        .romb_dout (romb_dout),
        .romb_ok   (romb_ok),
        .snda      (snda),
        .sndb      (sndb),
        .snd       (snd)
    );

    assign roma_ok   = ok_v[0];
    assign roma_dout = dout_v[0];
    assign romb_ok   = ok_v[1];
    assign romb_dout = dout_v[1];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // cen on every other cycle
    always @(negedge clk) begin
        cen = ~cen;
    end

    // sample period in cen_q ticks, reload tick included
    function automatic int period_of(logic [11:0] pre0, logic [1:0] sel);
        if (sel[0]) begin
            return 256 - pre0[7:0];
        end else if (sel[1]) begin
            return (pre0[11:8] == 4'hf) ? 1 : 12'hf01 - pre0;
        end
        return 4096 - pre0;
    endfunction

    function automatic int gain_of(int ch, logic [7:0] g);
        if ((ch == 0) == pcm_pkg::GAIN_A_HIGH) begin
            return g[7:4];
        end
        return g[3:0];
    endfunction

    task automatic report_value(string what, int exp, int act);
        errors++;
        $display("ERROR %s %s expected %0d actual %0d", test_name, what, exp, act);
    endtask

    // register shadow, trigger edge numbers, E/Q spacing and the run limit
    always @(posedge clk) begin : host_model
        logic [3:0] da;
        da  = addr ^ {3'b000, pcm_pkg::INVERT_A0};
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("timeout: run went past %0d cycles without finishing", TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end else if (rst) begin
            for (int i = 0; i < 14; i++) begin
                regs[i] <= 8'd0;
            end
            q_seen  = 1'b0;
            since_q = 0;
        end else begin
            if (dacs && da < 14) begin
                regs[da] <= din;
                if (da == 4'd5) begin
                    trig[0] <= cyc + 1;
                end
                if (da == 4'd11) begin
                    trig[1] <= cyc + 1;
                end
            end
            if (cen_q && cen_e) begin
                errors++;
                $display("ERROR %s cen_q and cen_e were high together", test_name);
            end
            if (cen) begin
                since_q++;
            end
            if (cen_q) begin
                if (q_seen && since_q != 4) begin
                    report_value("cen count between cen_q", 4, since_q);
                end
                since_q = 0;
                q_seen  = 1'b1;
                eq_pulses++;
            end
            if (cen_e && q_seen && since_q != 2) begin
                report_value("cen count from cen_q to cen_e", 2, since_q);
            end
        end
    end

    // ROM models, ok after 0 to max_delay cycles for each new address
    always @(negedge clk) begin : rom_model
        logic        cs_v;
        logic [16:0] a_v;
        for (int ch = 0; ch < 2; ch++) begin
            cs_v = (ch == 0) ? roma_cs : romb_cs;
            a_v  = (ch == 0) ? roma_addr : romb_addr;
            if (!cs_v) begin
                ok_v[ch]  = 1'b0;
                fresh[ch] = 1'b1;
            end else if (fresh[ch] || a_v != cur[ch]) begin
                fresh[ch] = 1'b0;
                cur[ch]   = a_v;
                wt[ch]    = (max_delay[ch] > 0) ? ($random(dly_seed) & 3) : 0;
                ok_v[ch]  = (wt[ch] == 0);
                // junk byte until ok
                dout_v[ch] = ok_v[ch] ? rom[ch][a_v[8:0]] : 8'($random(dly_seed));
            end else if (wt[ch] > 0) begin
                wt[ch]--;
                if (wt[ch] == 0) begin
                    ok_v[ch]   = 1'b1;
                    dout_v[ch] = rom[ch][a_v[8:0]];
                end
            end
        end
    end

    // one channel against the step rule, using the previous falling edge snapshot
    task automatic check_channel(int ch, logic cs_c, logic [16:0] addr_c, logic [6:0] smp_c);
        logic [7:0]  b;
        logic [6:0]  e;
        logic [16:0] st;
        logic        lp;
        int          base;
        base = ch * 6;
        st   = {regs_p[base + 4][0], regs_p[base + 3], regs_p[base + 2]};
        lp   = regs_p[13][ch];
        if (!cs_p[ch] && cs_c) begin
            checks++;
            if (cyc != trig[ch] + 1) begin
                report_value("rom_cs rise cycle", trig[ch] + 1, cyc);
            end
            if (addr_c != st) begin
                report_value("start address", st, addr_c);
            end
            steps_seen[ch] = 0;
            ticks[ch]      = 0;
        end else if (cs_p[ch] && (!cs_c || addr_c != addr_p[ch])) begin
            // a step consumed the byte at the old address
            b = rom[ch][addr_p[ch][8:0]];
            e = b[6:0] - 7'(pcm_pkg::SMP_OFFSET);
            checks++;
            if (smp_c != e) begin
                report_value("sample", $signed(e), $signed(smp_c));
            end
            if (!b[7]) begin
                if (!cs_c || addr_c != addr_p[ch] + 17'd1) begin
                    report_value("next address", addr_p[ch] + 17'd1, addr_c);
                end
            end else if (lp) begin
                if (!cs_c || addr_c != st) begin
                    report_value("loop address", st, addr_c);
                end
                loops[ch]++;
            end else if (cs_c) begin
                report_value("rom_cs after end marker", 0, 1);
            end
            if (check_period && steps_seen[ch] > 0) begin
                if (ticks[ch] != period_of({regs_p[base + 1][3:0], regs_p[base]},
                                           regs_p[base + 1][5:4])) begin
                    report_value("period ticks", period_of({regs_p[base + 1][3:0],
                                 regs_p[base]}, regs_p[base + 1][5:4]), ticks[ch]);
                end
            end
            if (!cs_c) begin
                done_cnt[ch]++;
            end
            steps_seen[ch]++;
            ticks[ch] = 0;
        end else if (!cs_p[ch] && !cs_c && smp_c != 7'd0) begin
            report_value("idle sample", 0, $signed(smp_c));
        end
    endtask

    always @(negedge clk) begin : monitor
        int sa;
        int sb;
        int exp;
        if (rst) begin
            mon_valid = 1'b0;
        end else begin
            if (mon_valid) begin
                check_channel(0, roma_cs, roma_addr, snda);
                check_channel(1, romb_cs, romb_addr, sndb);
                // snd follows the samples and gains of one cycle earlier
                sa  = $signed(smp_p[0]);
                sb  = $signed(smp_p[1]);
                exp = (sa * gain_of(0, regs_p[12]) + sb * gain_of(1, regs_p[12]))
                      >>> pcm_pkg::GAIN_SHIFT;
                checks++;
                if (snd != exp) begin
                    report_value("mixed output", exp, snd);
                end
            end
            for (int ch = 0; ch < 2; ch++) begin
                ticks[ch] += cen_q;
            end
            cs_p[0]   = roma_cs;
            cs_p[1]   = romb_cs;
            addr_p[0] = roma_addr;
            addr_p[1] = romb_addr;
            smp_p[0]  = snda;
            smp_p[1]  = sndb;
            regs_p    = regs;
            mon_valid = 1'b1;
        end
    end

    task automatic write_reg(logic [3:0] a, logic [7:0] d);
        @(negedge clk);
        dacs = 1'b1;
        addr = a;
        din  = d;
        @(negedge clk);
        dacs = 1'b0;
    endtask

    // random start, ROM image with one end marker, prescaler and loop bit
    task automatic setup_channel(int ch, logic [1:0] sel, int len, bit lp, int dly);
        logic [16:0] st;
        logic [11:0] pre0;
        logic [3:0]  base;
        st   = 17'($random(seed));
        base = 4'(ch * 6);
        pre0 = (sel == 2'b10) ? 12'hef0 : 12'hff0;
        pre0 = pre0 | 12'($random(seed) & 15);
        for (int i = 0; i < 512; i++) begin
            rom[ch][i] = 8'($random(seed)) & 8'h7f;
        end
        rom[ch][(st[8:0] + len) % 512] |= 8'h80;
        max_delay[ch] = dly;
        write_reg(base, pre0[7:0]);
        write_reg(base + 4'd1, {2'b00, sel, pre0[11:8]});
        write_reg(base + 4'd2, st[7:0]);
        write_reg(base + 4'd3, st[15:8]);
        write_reg(base + 4'd4, {7'd0, st[16]});
        write_reg(4'd13, lp ? (regs[13] | 8'(1 << ch)) : (regs[13] & ~8'(1 << ch)));
    endtask

    task automatic play_once(int ch, logic [1:0] sel, int len, int dly);
        int old;
        setup_channel(ch, sel, len, 1'b0, dly);
        old = done_cnt[ch];
        write_reg(4'(ch * 6 + 5), 8'h01);
        wait (done_cnt[ch] != old);
    endtask

    initial begin : stimulus
        int old_a;
        int old_b;
        logic [1:0] sels [3];
        seed      = 82;
        dly_seed  = 82;
        errors    = 0;
        checks    = 0;
        eq_pulses = 0;
        test_name = "reset";
        rst  = 1'b1;
        cen  = 1'b0;
        dacs = 1'b0;
        addr = 4'd0;
        din  = 8'd0;
        for (int ch = 0; ch < 2; ch++) begin
            ok_v[ch]      = 1'b0;
            dout_v[ch]    = 8'd0;
            fresh[ch]     = 1'b1;
            max_delay[ch] = 0;
            done_cnt[ch]  = 0;
            loops[ch]     = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "eq_enables";
        repeat (40) @(negedge clk);
        checks++;
        if (eq_pulses < 4) begin
            errors++;
            $display("ERROR %s cen_q pulsed only %0d times in 40 cycles", test_name, eq_pulses);
        end

        // each prescaler mode with ok always ready
        check_period = 1'b1;
        sels[0] = 2'b01;
        sels[1] = 2'b10;
        sels[2] = 2'b00;
        for (int m = 0; m < 3; m++) begin
            test_name = $sformatf("walk_sel%0d", sels[m]);
            write_reg(4'd12, 8'($random(seed)));
            play_once(0, sels[m], 8 + ($random(seed) & 7), 0);
        end

        test_name = "loop";
        setup_channel(0, 2'b01, 5, 1'b1, 0);
        old_a = done_cnt[0];
        old_b = loops[0];
        write_reg(4'd5, 8'h01);
        wait (loops[0] >= old_b + 2);
        write_reg(4'd13, regs[13] & 8'hfe);
        wait (done_cnt[0] != old_a);

        check_period = 1'b0;
        test_name = "backpressure";
        play_once(1, 2'b10, 12, 3);
        play_once(0, 2'b01, 9, 3);

        // both channels, B walks on while A plays and stops
        test_name = "mix";
        write_reg(4'd12, 8'($random(seed)));
        setup_channel(0, 2'b01, 10, 1'b0, 3);
        setup_channel(1, 2'b00, 14, 1'b0, 3);
        old_a = done_cnt[0];
        old_b = done_cnt[1];
        write_reg(4'd5, 8'h01);
        repeat (3) @(negedge clk);
        write_reg(4'd11, 8'h01);
        wait (done_cnt[0] != old_a && done_cnt[1] != old_b);
        repeat (4) @(negedge clk);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: pcm_sound_top.f
rtl/pcm_pkg.sv
rtl/pcm_rom_if.sv
rtl/pcm_regs.sv
rtl/pcm_channel.sv
rtl/pcm_mixer.sv
rtl/pcm_sound_top.sv
sim/tb_pcm_sound.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
TOP        := tb_pcm_sound
RTL_TOP    := pcm_sound_top
FILELIST   := pcm_sound_top.f
LOG        := sim.log
OBJ        := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)
